// File: Makefile
TOP := tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: include/dcache_defines.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// geometry of the L1 data cache, included by the packages and the RTL
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// byte address from the cpu
`define DC_ADDR_W    32

// 256 sets
`define DC_INDEX_W   8

// byte offset inside a 16-byte line
`define DC_OFFSET_W  4

`define DC_WORD_W    32
`define DC_WORDS     4

// whatever is left above index and offset
`define DC_TAG_W     (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif

// File: src/dcache_addr_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address and line types shared by the cache datapath
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dcache_defines.svh"

package dcache_addr_pkg;

    // upper address bits kept per way
    typedef logic [`DC_TAG_W-1:0] tag_t;

    // selects one of the sets
    typedef logic [`DC_INDEX_W-1:0] index_t;

    // word position inside a line, addr bits above the byte offset
    typedef logic [$clog2(`DC_WORDS)-1:0] word_sel_t;

    typedef logic [`DC_WORD_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [`DC_WORDS-1:0] line_t;

endpackage

// File: src/dcache_arrays.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// valid, tag, dirty and line storage for both ways plus one lru bit
// per set. reads are asynchronous and writes land on the clock edge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dcache_defines.svh"

module dcache_arrays (
    input  logic                    clk_tmp,
    input  logic                    rst_n,
    input  dcache_addr_pkg::index_t rd_index,
    input  logic                    wr_en,
    input  dcache_ctrl_pkg::way_e   wr_way,
    input  dcache_addr_pkg::index_t wr_index,
    input  dcache_addr_pkg::tag_t   wr_tag,
    input  dcache_addr_pkg::line_t  wr_line,
    input  logic                    wr_dirty,
    input  logic                    lru_en,
    input  dcache_ctrl_pkg::way_e   lru_way,
    output logic [1:0]              set_valid,
    output logic [1:0]              set_dirty,
    output dcache_addr_pkg::tag_t   set_tag0,
    output dcache_addr_pkg::tag_t   set_tag1,
    output dcache_addr_pkg::line_t  set_line0,
    output dcache_addr_pkg::line_t  set_line1,
    output dcache_ctrl_pkg::way_e   set_lru
);
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;

    localparam int SETS = 1 << `DC_INDEX_W;

    logic  valid_q [2][SETS];
    logic  dirty_q [2][SETS];
    tag_t  tag_q   [2][SETS];
    line_t line_q  [2][SETS];
    way_e  lru_q   [SETS];    // way to evict next

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[0][s] <= 1'b0;
                valid_q[1][s] <= 1'b0;
                lru_q[s]      <= WAY0;
            end
        end else begin
            if (wr_en) begin
                valid_q[wr_way][wr_index] <= 1'b1;
            end
            if (lru_en) begin
                lru_q[wr_index] <= (lru_way == WAY0) ? WAY1 : WAY0;  // other way ages
            end
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (wr_en) begin
            tag_q[wr_way][wr_index]   <= wr_tag;
            line_q[wr_way][wr_index]  <= wr_line;
            dirty_q[wr_way][wr_index] <= wr_dirty;  // clean on refill
        end
    end

    assign set_valid = {valid_q[1][rd_index], valid_q[0][rd_index]};
    assign set_dirty = {dirty_q[1][rd_index], dirty_q[0][rd_index]};
    assign set_tag0  = tag_q[0][rd_index];
    assign set_tag1  = tag_q[1][rd_index];
    assign set_line0 = line_q[0][rd_index];
    assign set_line1 = line_q[1][rd_index];
    assign set_lru   = lru_q[rd_index];

    // the controller keeps its strobes quiet once reset has been seen
    a_no_wr_in_reset: assert property (@(posedge clk_tmp)
        !rst_n |=> !(wr_en || lru_en));

endmodule

// File: src/dcache_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache FSM for hit handling, line merge, writeback and refill
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dcache_defines.svh"

module dcache_ctrl (
    input  logic                     clk_tmp,
    input  logic                     rst_n,
    input  logic                     cpu_req,
    input  logic                     cpu_we,
    input  logic [`DC_ADDR_W-1:0]    cpu_addr,
    input  dcache_addr_pkg::word_t   cpu_wdata,
    input  logic                     hit,
    input  dcache_ctrl_pkg::way_e    hit_way,
    input  dcache_ctrl_pkg::way_e    victim_way,
    input  logic                     victim_dirty,
    input  dcache_addr_pkg::tag_t    victim_tag,
    input  dcache_addr_pkg::line_t   hit_line,
    input  dcache_addr_pkg::word_t   hit_word,
    input  logic                     mem_ack,
    input  dcache_addr_pkg::line_t   mem_rdata,
    output logic                     cpu_done,
    output dcache_addr_pkg::word_t   cpu_rdata,
    output logic                     cpu_stall,
    output logic                     mem_req,
    output dcache_ctrl_pkg::mem_op_e mem_op,
    output logic [`DC_ADDR_W-1:0]    mem_addr,
    output dcache_addr_pkg::line_t   mem_wdata,
    output logic                     wr_en,
    output dcache_ctrl_pkg::way_e    wr_way,
    output dcache_addr_pkg::index_t  wr_index,
    output dcache_addr_pkg::tag_t    wr_tag,
    output dcache_addr_pkg::line_t   wr_line,
    output logic                     wr_dirty,
    output logic                     lru_en,
    output dcache_ctrl_pkg::way_e    lru_way
);
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;

    dc_state_e state;
    way_e      victim_q;      // way picked when the miss was seen
    tag_t      addr_tag;
    index_t    addr_index;
    word_sel_t word_sel;
    line_t     merged_line;

    assign addr_tag   = cpu_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign addr_index = cpu_addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign word_sel   = cpu_addr[`DC_OFFSET_W-1:2];

    // cpu_addr is held until done, so the array address follows it
    assign wr_index = addr_index;
    assign wr_tag   = addr_tag;

    always_comb begin
        merged_line           = hit_line;
        merged_line[word_sel] = cpu_wdata;
    end

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            state     <= IDLE;
            cpu_done  <= 1'b0;
            cpu_stall <= 1'b0;
            mem_req   <= 1'b0;
            wr_en     <= 1'b0;
            lru_en    <= 1'b0;
        end else begin
            cpu_done <= 1'b0;     // all pulses
            wr_en    <= 1'b0;
            lru_en   <= 1'b0;
            case (state)
                IDLE: begin
                    if (cpu_req && !cpu_done) begin   // old request still up during done
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        cpu_stall <= 1'b0;
                        lru_en    <= 1'b1;
                        wr_en     <= cpu_we;
                        state     <= RESPOND;
                    end else begin
                        cpu_stall <= 1'b1;
                        if (victim_dirty) begin
                            mem_req <= 1'b1;
                            state   <= WRITEBACK;
                        end else begin
                            state <= REFILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;  // one idle cycle before the read
                        state   <= REFILL;
                    end
                end
                REFILL: begin
                    if (!mem_req) begin
                        mem_req <= 1'b1;
                    end else if (mem_ack) begin
                        mem_req <= 1'b0;
                        wr_en   <= 1'b1;
                        state   <= FILL;
                    end
                end
                FILL: begin
                    state <= LOOKUP;      // fresh lookup now hits
                end
                RESPOND: begin
                    cpu_done <= 1'b1;
                    state    <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (state == LOOKUP) begin
            victim_q  <= victim_way;
            cpu_rdata <= hit_word;
            mem_wdata <= hit_line;           // victim line on a miss
            wr_way    <= hit_way;
            wr_line   <= merged_line;
            wr_dirty  <= 1'b1;
            lru_way   <= hit_way;
            if (!hit && victim_dirty) begin
                mem_op   <= WRITE_LINE;
                mem_addr <= {victim_tag, addr_index, {`DC_OFFSET_W{1'b0}}};
            end
        end
        if (state == REFILL && !mem_req) begin
            mem_op   <= READ_LINE;
            mem_addr <= {addr_tag, addr_index, {`DC_OFFSET_W{1'b0}}};
        end
        if (state == REFILL && mem_req && mem_ack) begin
            wr_way   <= victim_q;
            wr_line  <= mem_rdata;
            wr_dirty <= 1'b0;
        end
    end

    // a next-level request holds until the memory acks it
    a_mem_stable: assert property (@(posedge clk_tmp) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_op));

    a_done_pulse: assert property (@(posedge clk_tmp) disable iff (!rst_n)
        cpu_done |=> !cpu_done);

endmodule

// File: src/dcache_ctrl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control types for the cache FSM, next-level opcodes and way select
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dcache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,    // dirty victim on its way out
        REFILL,       // waiting for the new line
        FILL,         // line goes into the arrays
        RESPOND
    } dc_state_e;

    typedef enum logic {READ_LINE, WRITE_LINE} mem_op_e;

    typedef enum logic {WAY0, WAY1} way_e;

endpackage

// File: src/dcache_lookup.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational tag compare and victim choice for the addressed set
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dcache_defines.svh"

module dcache_lookup (
    input  logic [`DC_ADDR_W-1:0]   cpu_addr,
    input  logic [1:0]              set_valid,
    input  logic [1:0]              set_dirty,
    input  dcache_addr_pkg::tag_t   set_tag0,
    input  dcache_addr_pkg::tag_t   set_tag1,
    input  dcache_addr_pkg::line_t  set_line0,
    input  dcache_addr_pkg::line_t  set_line1,
    input  dcache_ctrl_pkg::way_e   set_lru,
    output logic                    hit,
    output dcache_ctrl_pkg::way_e   hit_way,
    output dcache_ctrl_pkg::way_e   victim_way,
    output logic                    victim_dirty,
    output dcache_addr_pkg::tag_t   victim_tag,
    output dcache_addr_pkg::line_t  hit_line,
    output dcache_addr_pkg::word_t  hit_word
);
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;

    tag_t      addr_tag;
    word_sel_t word_sel;
    logic      hit0;
    logic      hit1;
    way_e      line_way;

    assign addr_tag = cpu_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign word_sel = cpu_addr[`DC_OFFSET_W-1:2];

    assign hit0    = set_valid[0] && (set_tag0 == addr_tag);
    assign hit1    = set_valid[1] && (set_tag1 == addr_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit0 ? WAY0 : WAY1;

    // empty ways are used up before the lru bit is consulted
    always_comb begin
        if (!set_valid[0]) begin
            victim_way = WAY0;
        end else if (!set_valid[1]) begin
            victim_way = WAY1;
        end else begin
            victim_way = set_lru;
        end
    end

    assign victim_dirty = set_valid[victim_way] && set_dirty[victim_way];
    assign victim_tag   = (victim_way == WAY1) ? set_tag1 : set_tag0;

    // on a miss the victim line comes out here, for the writeback
    assign line_way = hit ? hit_way : victim_way;
    assign hit_line = (line_way == WAY1) ? set_line1 : set_line0;
    assign hit_word = hit_line[word_sel];

endmodule

// File: src/dcache_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-way write-back L1 data cache, cpu port and line-wide memory port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dcache_defines.svh"

module dcache_top (
    input  logic                     clk_tmp,
    input  logic                     rst_n,
    input  logic                     cpu_req,
    input  logic                     cpu_we,
    input  logic [`DC_ADDR_W-1:0]    cpu_addr,
    input  dcache_addr_pkg::word_t   cpu_wdata,
    output logic                     cpu_done,
    output dcache_addr_pkg::word_t   cpu_rdata,
    output logic                     cpu_stall,
    output logic                     mem_req,
    output dcache_ctrl_pkg::mem_op_e mem_op,
    output logic [`DC_ADDR_W-1:0]    mem_addr,
    output dcache_addr_pkg::line_t   mem_wdata,
    input  logic                     mem_ack,
    input  dcache_addr_pkg::line_t   mem_rdata
);
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;

    // set contents for the current address
    logic [1:0] set_valid;
    logic [1:0] set_dirty;
    tag_t       set_tag0;
    tag_t       set_tag1;
    line_t      set_line0;
    line_t      set_line1;
    way_e       set_lru;

    // lookup results
    logic       hit;
    way_e       hit_way;
    way_e       victim_way;
    logic       victim_dirty;
    tag_t       victim_tag;
    line_t      hit_line;
    word_t      hit_word;

    // array update from ctrl
    logic       wr_en;
    way_e       wr_way;
    index_t     wr_index;
    tag_t       wr_tag;
    line_t      wr_line;
    logic       wr_dirty;
    logic       lru_en;
    way_e       lru_way;

    dcache_arrays i_arrays (
        .rd_index (cpu_addr[`DC_OFFSET_W +: `DC_INDEX_W]),
        .*
    );

    dcache_lookup i_lookup (.*);

    dcache_ctrl i_ctrl (.*);

endmodule

// File: test/dcache_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench checker, watches the cache ports against a word memory model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dcache_defines.svh"

module dcache_checker (
    input  logic                     clk_tmp,
    input  logic                     rst_n,
    input  logic                     cpu_req,
    input  logic                     cpu_we,
    input  logic [`DC_ADDR_W-1:0]    cpu_addr,
    input  dcache_addr_pkg::word_t   cpu_wdata,
    input  logic                     cpu_done,
    input  dcache_addr_pkg::word_t   cpu_rdata,
    input  logic                     cpu_stall,
    input  logic                     mem_req,
    input  dcache_ctrl_pkg::mem_op_e mem_op,
    input  logic [`DC_ADDR_W-1:0]    mem_addr,
    input  dcache_addr_pkg::line_t   mem_wdata,
    input  logic                     mem_ack,
    output int                       error_count,
    output int                       check_count
);
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;

    word_t       ref_mem [logic [29:0]];      // by word address
    bit          dirty_lines [logic [27:0]];  // written since last refill
    logic        busy;
    logic        expect_hit;
    logic        have_last;
    logic        req_we;
    logic [31:0] req_addr;
    logic [31:0] last_addr;
    word_t       req_wdata;
    int          cycle;
    int          start_cycle;
    logic        mem_open;                    // request seen without its ack
    logic [31:0] open_addr;
    mem_op_e     open_op;

    // never-written words, same pattern as the memory model
    function automatic word_t fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic word_t expected_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic report_value(input string name, input line_t got, input line_t exp);
        $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("%0t: %s", $time, what);
        error_count++;
    endtask

    task automatic check_writeback();
        logic [31:0] word_addr;
        if (!dirty_lines.exists(mem_addr[31:4])) begin
            report_failure("line written back without a write since its refill");
        end
        for (int w = 0; w < `DC_WORDS; w++) begin
            word_addr = {mem_addr[31:4], 4'h0} + 32'(4 * w);
            check_count++;
            if (mem_wdata[w] != expected_word(word_addr)) begin
                report_value("mem_wdata", line_t'(mem_wdata[w]),
                             line_t'(expected_word(word_addr)));
            end
        end
        dirty_lines.delete(mem_addr[31:4]);  // line leaves the cache
    endtask

    always @(posedge clk_tmp) begin
        if (!rst_n) begin
            busy        = 1'b0;
            have_last   = 1'b0;
            mem_open    = 1'b0;
            cycle       = 0;
            error_count = 0;
            check_count = 0;
        end else begin
            cycle++;
            if (busy && expect_hit && cpu_stall) begin
                report_failure("cpu_stall raised on a read that should hit");
            end
            if (busy && cpu_done) begin
                // done is registered after RESPOND, seen 3 edges after the start
                if (expect_hit && (cycle - start_cycle != 3)) begin
                    report_failure("repeated read did not complete as a hit");
                end
                if (cpu_stall) begin
                    report_failure("cpu_stall still high when cpu_done arrived");
                end
                if (req_we) begin
                    ref_mem[req_addr[31:2]]     = req_wdata;
                    dirty_lines[req_addr[31:4]] = 1'b1;
                end else begin
                    check_count++;
                    if (cpu_rdata != expected_word(req_addr)) begin
                        report_value("cpu_rdata", line_t'(cpu_rdata),
                                     line_t'(expected_word(req_addr)));
                    end
                end
                last_addr = req_addr;
                have_last = 1'b1;
                busy      = 1'b0;
            end else if (!busy && cpu_req && !cpu_done) begin
                busy        = 1'b1;
                start_cycle = cycle;
                req_we      = cpu_we;
                req_addr    = cpu_addr;
                req_wdata   = cpu_wdata;
                expect_hit  = have_last && !cpu_we && (cpu_addr == last_addr);
            end
            if (mem_req && !cpu_stall) begin
                report_failure("cpu_stall low while a line request is open");
            end
            if (mem_open && (!mem_req || mem_addr != open_addr || mem_op != open_op)) begin
                report_failure("next-level request changed before its ack");
            end
            if (mem_req && mem_ack) begin
                if (mem_op == WRITE_LINE) begin
                    check_writeback();
                end else begin
                    check_count++;
                    if (!busy || mem_addr[3:0] != 4'h0 ||
                        mem_addr[31:4] != req_addr[31:4]) begin
                        report_failure("line read does not match the pending cpu request");
                    end
                    dirty_lines.delete(mem_addr[31:4]);   // refilled clean
                end
            end
            mem_open  = mem_req && !mem_ack;
            open_addr = mem_addr;
            open_op   = mem_op;
        end
    end

endmodule

// File: test/tb_dcache.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the data cache, random cpu traffic and a delayed memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dcache_defines.svh"

module tb_dcache;
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;

    localparam int ACCESSES = 400;
    localparam int MAX_WAIT = 100;   // cycles per cpu request

    logic                  clk_tmp = 1'b0;
    logic                  rst_n;
    logic                  cpu_req;
    logic                  cpu_we;
    logic [`DC_ADDR_W-1:0] cpu_addr;
    word_t                 cpu_wdata;
    logic                  cpu_done;
    word_t                 cpu_rdata;
    logic                  cpu_stall;
    logic                  mem_req;
    mem_op_e               mem_op;
    logic [`DC_ADDR_W-1:0] mem_addr;
    line_t                 mem_wdata;
    logic                  mem_ack = 1'b0;
    line_t                 mem_rdata = '0;
    int                    error_count;
    int                    check_count;

    logic [31:0] lfsr;
    line_t       lines [logic [27:0]];   // next-level memory by line address
    logic        mem_busy = 1'b0;
    int          mem_delay = 0;
    logic        timed_out;
    int          waited;
    int          accesses_done;
    logic [31:0] last_addr;

    dcache_top i_dut (.*);

    dcache_checker i_checker (.*);

    always #5 clk_tmp = ~clk_tmp;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic line_t read_line(input logic [27:0] line_addr);
        line_t fresh;
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        for (int w = 0; w < `DC_WORDS; w++) begin
            fresh[w] = fill_word({line_addr, 4'h0} + 32'(4 * w));
        end
        return fresh;
    endfunction

    // memory draws only while a cpu request is open, stimulus only between requests
    always @(negedge clk_tmp) begin
        mem_ack = 1'b0;
        if (rst_n && mem_req && !mem_busy) begin
            mem_busy  = 1'b1;
            mem_delay = rand_bits(2);   // 0 to 3 cycles
        end
        if (mem_busy) begin
            if (mem_delay == 0) begin
                if (mem_op == WRITE_LINE) begin
                    lines[mem_addr[31:4]] = mem_wdata;
                end else begin
                    mem_rdata = read_line(mem_addr[31:4]);
                end
                mem_ack  = 1'b1;
                mem_busy = 1'b0;
            end else begin
                mem_delay--;
            end
        end
    end

    initial begin
        lfsr          = 32'h5561b6d5;
        rst_n         = 1'b0;
        cpu_req       = 1'b0;
        cpu_we        = 1'b0;
        cpu_addr      = '0;
        cpu_wdata     = '0;
        timed_out     = 1'b0;
        accesses_done = 0;
        last_addr     = '0;
        repeat (5) @(negedge clk_tmp);
        rst_n = 1'b1;
        for (int n = 0; n < ACCESSES && !timed_out; n++) begin
            @(negedge clk_tmp);
            if (n > 0 && rand_bits(1) == 1) begin
                cpu_we   = 1'b0;     // re-read of the last address
                cpu_addr = last_addr;
            end else begin
                cpu_we   = rand_bits(1);
                cpu_addr = rand_bits(3) << 12;          // tag, 8 per set
                cpu_addr = cpu_addr | (rand_bits(1) << 4);   // two sets
                cpu_addr = cpu_addr | (rand_bits(2) << 2);
            end
            cpu_wdata = rand_bits(32);
            cpu_req   = 1'b1;
            waited    = 0;
            while (!cpu_done && waited < MAX_WAIT) begin
                @(negedge clk_tmp);
                waited++;
            end
            cpu_req = 1'b0;
            if (!cpu_done) begin
                $display("%0t: cpu request to %h got no done", $time, cpu_addr);
                timed_out = 1'b1;
            end else begin
                accesses_done++;
                last_addr = cpu_addr;
            end
        end
        repeat (2) @(negedge clk_tmp);
        $display("%0d accesses, %0d checks, %0d errors, %0d timeouts",
                 accesses_done, check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
src/dcache_addr_pkg.sv
src/dcache_ctrl_pkg.sv
src/dcache_lookup.sv
src/dcache_arrays.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/dcache_checker.sv
test/tb_dcache.sv
